//--- all.f
verilog/cpu_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/instruction_decoder.sv
verilog/controller.sv
verilog/datapath.sv
verilog/address_unit.sv
verilog/cpu.sv
verification/tb_clock.sv
verification/memory_model.sv
verification/cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps --top-module cpu_tb \
    -f all.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- verification/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int addr_width = 9;
    localparam int num_rows = 8;
    localparam int prog_len = 8;
    localparam int halt_wait = 20;
    localparam int cycle_limit = num_rows * prog_len * 11 * 2;

    logic clk, por, row_reset, cpu_reset;
    logic load;
    logic [prog_len-1:0][word_width-1:0] prog_words;
    logic [addr_width-1:0] data_addr;
    logic [word_width-1:0] data_word;
    logic [1:0] mem_cmd;
    logic [addr_width-1:0] mem_addr;
    logic [word_width-1:0] read_data, write_data;
    logic n, v, z, halted;

    // Test table
    string row_name [num_rows];
    logic [prog_len-1:0][word_width-1:0] row_prog [num_rows];
    logic [addr_width-1:0] row_data_addr [num_rows];
    logic [word_width-1:0] row_data [num_rows];
    logic [addr_width-1:0] exp_addr [num_rows];
    logic [word_width-1:0] exp_value [num_rows];
    logic row_has_cmp [num_rows];
    logic [2:0] exp_nvz [num_rows]; // {n, v, z}

    integer seed;
    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    // Bus monitor state
    int store_count = 0;
    int halt_writes = 0;
    logic read_seen = 1'b0;
    logic [addr_width-1:0] first_read_addr = '0;
    logic [addr_width-1:0] last_store_addr = '0;
    logic [word_width-1:0] last_store_data = '0;

    assign cpu_reset = por | row_reset;

    tb_clock u_clock (
        .clk(clk),
        .reset(por)
    );

    memory_model #(
        .addr_width(addr_width),
        .prog_len(prog_len)
    ) u_memory (
        .clk(clk),
        .load(load),
        .program_words(prog_words),
        .data_addr(data_addr),
        .data_word(data_word),
        .mem_cmd(mem_cmd),
        .mem_addr(mem_addr),
        .write_data(write_data),
        .read_data(read_data)
    );

    cpu #(
        .addr_width(addr_width)
    ) dut (
        .clk(clk),
        .reset(cpu_reset),
        .read_data(read_data),
        .mem_cmd(mem_cmd),
        .mem_addr(mem_addr),
        .write_data(write_data),
        .n(n),
        .v(v),
        .z(z),
        .halted(halted)
    );

    function automatic logic [15:0] reg_instr(logic [2:0] opc, logic [1:0] sub,
            logic [2:0] rn, logic [2:0] rd, logic [1:0] sh, logic [2:0] rm);
        instr_t w;
        w = '0;
        w.reg_view.opcode = opc;
        w.reg_view.op = sub;
        w.reg_view.rn = rn;
        w.reg_view.rd = rd;
        w.reg_view.shift = sh;
        w.reg_view.rm = rm;
        return w;
    endfunction

    function automatic logic [15:0] imm8_instr(logic [2:0] opc, logic [1:0] sub,
            logic [2:0] rn, logic [7:0] imm8);
        instr_t w;
        w = '0;
        w.imm8_view.opcode = opc;
        w.imm8_view.op = sub;
        w.imm8_view.rn = rn;
        w.imm8_view.imm8 = imm8;
        return w;
    endfunction

    function automatic logic [15:0] imm5_instr(logic [2:0] opc, logic [1:0] sub,
            logic [2:0] rn, logic [2:0] rd, logic [4:0] imm5);
        instr_t w;
        w = '0;
        w.imm5_view.opcode = opc;
        w.imm5_view.op = sub;
        w.imm5_view.rn = rn;
        w.imm5_view.rd = rd;
        w.imm5_view.imm5 = imm5;
        return w;
    endfunction

    task automatic build_table();
        logic [31:0] rnd;
        logic [7:0] a8, b8;
        logic [15:0] sa, sb;
        for (int r = 0; r < num_rows; r++) begin
            for (int k = 0; k < prog_len; k++) begin
                row_prog[r][k] = imm8_instr(op_halt, 2'b00, 3'd0, 8'd0);
            end
            row_data_addr[r] = 9'd100;
            row_data[r] = '0;
            row_has_cmp[r] = 1'b0;
            exp_nvz[r] = 3'b000;
        end

        // Negative immediate plus twice a positive one
        rnd = $random(seed);
        a8 = rnd[7:0] | 8'h80;
        b8 = rnd[15:8] & 8'h7f;
        sa = {{8{a8[7]}}, a8};
        sb = {8'h00, b8};
        row_name[0] = "mov_add_lsl_str";
        row_prog[0][0] = imm8_instr(op_move, mov_imm, 3'd0, a8);
        row_prog[0][1] = imm8_instr(op_move, mov_imm, 3'd1, b8);
        row_prog[0][2] = reg_instr(op_alu, alu_add, 3'd0, 3'd2, sh_lsl, 3'd1);
        row_prog[0][3] = imm8_instr(op_move, mov_imm, 3'd7, 8'd64);
        row_prog[0][4] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[0] = 9'd64;
        exp_value[0] = sa + {sb[14:0], 1'b0};

        rnd = $random(seed);
        a8 = rnd[7:0];
        b8 = rnd[15:8];
        sa = {{8{a8[7]}}, a8};
        sb = {{8{b8[7]}}, b8};
        row_name[1] = "and";
        row_prog[1][0] = imm8_instr(op_move, mov_imm, 3'd0, a8);
        row_prog[1][1] = imm8_instr(op_move, mov_imm, 3'd1, b8);
        row_prog[1][2] = reg_instr(op_alu, alu_and, 3'd0, 3'd2, sh_none, 3'd1);
        row_prog[1][3] = imm8_instr(op_move, mov_imm, 3'd7, 8'd65);
        row_prog[1][4] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[1] = 9'd65;
        exp_value[1] = sa & sb;

        rnd = $random(seed);
        b8 = rnd[7:0] | 8'h80;
        sb = {{8{b8[7]}}, b8};
        row_name[2] = "mvn_asr";
        row_prog[2][0] = imm8_instr(op_move, mov_imm, 3'd1, b8);
        row_prog[2][1] = reg_instr(op_alu, alu_mvn, 3'd0, 3'd2, sh_asr, 3'd1);
        row_prog[2][2] = imm8_instr(op_move, mov_imm, 3'd7, 8'd66);
        row_prog[2][3] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[2] = 9'd66;
        exp_value[2] = ~{sb[15], sb[15:1]};

        rnd = $random(seed);
        b8 = rnd[7:0] | 8'h80; // Sign bit set so LSR differs from ASR
        sb = {{8{b8[7]}}, b8};
        row_name[3] = "mov_reg_lsr";
        row_prog[3][0] = imm8_instr(op_move, mov_imm, 3'd1, b8);
        row_prog[3][1] = reg_instr(op_move, mov_reg, 3'd0, 3'd2, sh_lsr, 3'd1);
        row_prog[3][2] = imm8_instr(op_move, mov_imm, 3'd7, 8'd67);
        row_prog[3][3] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[3] = 9'd67;
        exp_value[3] = {1'b0, sb[15:1]};

        // Equal operands then an ADD that must leave the flags alone
        rnd = $random(seed);
        a8 = rnd[7:0] | 8'h01; // Nonzero so the ADD result is nonzero
        sa = {{8{a8[7]}}, a8};
        row_name[4] = "cmp_equal";
        row_prog[4][0] = imm8_instr(op_move, mov_imm, 3'd0, a8);
        row_prog[4][1] = imm8_instr(op_move, mov_imm, 3'd1, a8);
        row_prog[4][2] = reg_instr(op_alu, alu_cmp, 3'd0, 3'd0, sh_none, 3'd1);
        row_prog[4][3] = reg_instr(op_alu, alu_add, 3'd0, 3'd2, sh_none, 3'd1);
        row_prog[4][4] = imm8_instr(op_move, mov_imm, 3'd7, 8'd68);
        row_prog[4][5] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[4] = 9'd68;
        exp_value[4] = sa + sa;
        row_has_cmp[4] = 1'b1;
        exp_nvz[4] = 3'b001;

        rnd = $random(seed);
        a8 = {2'b00, rnd[5:0]};
        b8 = a8 + 8'd1 + {3'b000, rnd[12:8]}; // Always above a8 and still positive
        sa = {8'h00, a8};
        sb = {8'h00, b8};
        row_name[5] = "cmp_negative";
        row_prog[5][0] = imm8_instr(op_move, mov_imm, 3'd0, a8);
        row_prog[5][1] = imm8_instr(op_move, mov_imm, 3'd1, b8);
        row_prog[5][2] = reg_instr(op_alu, alu_cmp, 3'd0, 3'd0, sh_none, 3'd1);
        row_prog[5][3] = reg_instr(op_alu, alu_and, 3'd0, 3'd2, sh_none, 3'd1);
        row_prog[5][4] = imm8_instr(op_move, mov_imm, 3'd7, 8'd69);
        row_prog[5][5] = imm5_instr(op_str, 2'b00, 3'd7, 3'd2, 5'd0);
        exp_addr[5] = 9'd69;
        exp_value[5] = sa & sb;
        row_has_cmp[5] = 1'b1;
        exp_nvz[5] = 3'b100;

        // 0x7fff minus -1 overflows to 0x8000
        row_name[6] = "cmp_overflow";
        row_prog[6][0] = imm8_instr(op_move, mov_imm, 3'd1, 8'hff);
        row_prog[6][1] = reg_instr(op_move, mov_reg, 3'd0, 3'd0, sh_lsr, 3'd1);
        row_prog[6][2] = reg_instr(op_alu, alu_cmp, 3'd0, 3'd0, sh_none, 3'd1);
        row_prog[6][3] = imm8_instr(op_move, mov_imm, 3'd7, 8'd70);
        row_prog[6][4] = imm5_instr(op_str, 2'b00, 3'd7, 3'd0, 5'd0);
        exp_addr[6] = 9'd70;
        exp_value[6] = 16'h7fff;
        row_has_cmp[6] = 1'b1;
        exp_nvz[6] = 3'b110;

        rnd = $random(seed);
        row_name[7] = "ldr_str_negative_offset";
        row_data_addr[7] = 9'd80;
        row_data[7] = rnd[15:0];
        row_prog[7][0] = imm8_instr(op_move, mov_imm, 3'd7, 8'd84);
        row_prog[7][1] = imm5_instr(op_ldr, 2'b00, 3'd7, 3'd3, 5'b11100); // 84 - 4
        row_prog[7][2] = imm5_instr(op_str, 2'b00, 3'd7, 3'd3, 5'b11110); // 84 - 2
        exp_addr[7] = 9'd82;
        exp_value[7] = rnd[15:0];
    endtask

    task automatic run_row(input int r);
        int halt_drops;
        @(posedge clk);
        #1;
        row_reset = 1'b1;
        load = 1'b1;
        prog_words = row_prog[r];
        data_addr = row_data_addr[r];
        data_word = row_data[r];
        @(posedge clk);
        #1;
        load = 1'b0;
        @(negedge clk);
        checks = checks + 2;
        if (mem_cmd !== mem_none) begin
            errors++;
            $display("Error %s: mem_cmd in reset expected %b, actual %b",
                row_name[r], mem_none, mem_cmd);
        end
        if (halted !== 1'b0) begin
            errors++;
            $display("Error %s: halted in reset expected 0, actual %b", row_name[r], halted);
        end
        @(posedge clk);
        #1;
        row_reset = 1'b0;

        halt_drops = 0;
        while (halted !== 1'b1) @(negedge clk);
        repeat (halt_wait) begin
            @(posedge clk);
            #1;
            if (halted !== 1'b1) begin
                halt_drops++;
            end
        end

        checks = checks + 6;
        if (halt_drops != 0) begin
            errors++;
            $display("%s: halted dropped in %0d cycles before reset", row_name[r], halt_drops);
        end
        if (halt_writes != 0) begin
            errors++;
            $display("%s: memory written %0d times after HALT", row_name[r], halt_writes);
        end
        if (!read_seen) begin
            errors++;
            $display("%s: no fetch seen after reset", row_name[r]);
        end else if (first_read_addr !== '0) begin
            errors++;
            $display("Error %s: first fetch address expected %h, actual %h",
                row_name[r], 9'h000, first_read_addr);
        end
        if (store_count != 1) begin
            errors++;
            $display("Error %s: store count expected 1, actual %0d", row_name[r], store_count);
        end
        if (last_store_addr !== exp_addr[r]) begin
            errors++;
            $display("Error %s: store address expected %h, actual %h",
                row_name[r], exp_addr[r], last_store_addr);
        end
        if (last_store_data !== exp_value[r]) begin
            errors++;
            $display("Error %s: store data expected %h, actual %h",
                row_name[r], exp_value[r], last_store_data);
        end
        if (row_has_cmp[r]) begin
            checks++;
            if ({n, v, z} !== exp_nvz[r]) begin
                errors++;
                $display("Error %s: flags nvz expected %b, actual %b",
                    row_name[r], exp_nvz[r], {n, v, z});
            end
        end
    endtask

    // Memory bus monitor that clears while reset is high
    always @(negedge clk) begin
        if (cpu_reset) begin
            store_count = 0;
            halt_writes = 0;
            read_seen = 1'b0;
            first_read_addr = '0;
            last_store_addr = '0;
            last_store_data = '0;
        end else begin
            if (mem_cmd == mem_read && !read_seen) begin
                read_seen = 1'b1;
                first_read_addr = mem_addr;
            end
            if (mem_cmd == mem_write) begin
                if (halted) begin
                    halt_writes++;
                end else begin
                    store_count++;
                    last_store_addr = mem_addr;
                    last_store_data = write_data;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: CPU never halted within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        seed = 32'h078e_9f6e;
        row_reset = 1'b1;
        load = 1'b0;
        prog_words = '0;
        data_addr = '0;
        data_word = '0;
        build_table();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/memory_model.sv
`timescale 1ns/1ps
`default_nettype none

module memory_model import cpu_pkg::*; #(
    parameter int addr_width = 9,
    parameter int prog_len = 8
) (
    input wire logic clk,
    input wire logic load,
    input wire logic [prog_len-1:0][word_width-1:0] program_words,
    input wire logic [addr_width-1:0] data_addr,
    input wire logic [word_width-1:0] data_word,
    input wire logic [1:0] mem_cmd,
    input wire logic [addr_width-1:0] mem_addr,
    input wire logic [word_width-1:0] write_data,
    output logic [word_width-1:0] read_data
);

    localparam int depth = 1 << addr_width;

    logic [word_width-1:0] words [depth];

    always_ff @(posedge clk) begin
        if (load) begin
            // Fill decodes as HALT with the address in the low bits
            for (int i = 0; i < depth; i++) begin
                words[i] <= 16'he000 | word_width'(i);
            end
            for (int i = 0; i < prog_len; i++) begin
                words[i] <= program_words[i];
            end
            words[data_addr] <= data_word;
        end else if (mem_cmd == mem_write) begin
            words[mem_addr] <= write_data;
        end
    end

    assign read_data = (mem_cmd == mem_read) ? words[mem_addr] : '0;

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period = 5,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Power-on reset released just after an edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verilog/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
    parameter int addr_width = 9
) (
    input wire logic clk,
    input wire logic reset,
    input wire logic [word_width-1:0] read_data,
    output logic [1:0] mem_cmd,
    output logic [addr_width-1:0] mem_addr,
    output logic [word_width-1:0] write_data,
    output logic n,
    output logic v,
    output logic z,
    output logic halted
);

    logic [2:0] opcode;
    logic [1:0] op;
    logic [1:0] shift;
    logic [reg_num_width-1:0] readnum;
    logic [reg_num_width-1:0] writenum;
    logic [word_width-1:0] sximm5;
    logic [word_width-1:0] sximm8;

    logic [2:0] nsel;
    logic write, loada, loadb, loadc, loads;
    logic asel, bsel;
    logic [1:0] vsel;
    logic [1:0] alu_op;
    logic load_ir, load_pc, reset_pc, load_addr, addr_sel;

    instruction_decoder u_decoder (
        .clk(clk),
        .load_ir(load_ir),
        .read_data(read_data),
        .nsel(nsel),
        .opcode(opcode),
        .op(op),
        .shift(shift),
        .readnum(readnum),
        .writenum(writenum),
        .sximm5(sximm5),
        .sximm8(sximm8)
    );

    controller u_controller (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .op(op),
        .nsel(nsel),
        .write(write),
        .loada(loada),
        .loadb(loadb),
        .loadc(loadc),
        .loads(loads),
        .asel(asel),
        .bsel(bsel),
        .vsel(vsel),
        .alu_op(alu_op),
        .load_ir(load_ir),
        .load_pc(load_pc),
        .reset_pc(reset_pc),
        .load_addr(load_addr),
        .addr_sel(addr_sel),
        .mem_cmd(mem_cmd),
        .halted(halted)
    );

    datapath u_datapath (
        .clk(clk),
        .read_data(read_data),
        .sximm5(sximm5),
        .sximm8(sximm8),
        .readnum(readnum),
        .writenum(writenum),
        .write(write),
        .loada(loada),
        .loadb(loadb),
        .loadc(loadc),
        .loads(loads),
        .asel(asel),
        .bsel(bsel),
        .vsel(vsel),
        .shift(shift),
        .alu_op(alu_op),
        .write_data(write_data),
        .n(n),
        .v(v),
        .z(z)
    );

    address_unit #(
        .addr_width(addr_width)
    ) u_address_unit (
        .clk(clk),
        .load_pc(load_pc),
        .reset_pc(reset_pc),
        .load_addr(load_addr),
        .addr_sel(addr_sel),
        .c_value(write_data), // C register doubles as store data
        .mem_addr(mem_addr)
    );

endmodule

`default_nettype wire

//--- verilog/address_unit.sv
`timescale 1ns/1ps
`default_nettype none

module address_unit import cpu_pkg::*; #(
    parameter int addr_width = 9
) (
    input wire logic clk,
    input wire logic load_pc,
    input wire logic reset_pc,
    input wire logic load_addr,
    input wire logic addr_sel,
    input wire logic [word_width-1:0] c_value,
    output logic [addr_width-1:0] mem_addr
);

    logic [addr_width-1:0] pc;
    logic [addr_width-1:0] data_addr;
    logic [addr_width-1:0] next_pc;

    assign next_pc = reset_pc ? '0 : pc + addr_width'(1);

    always_ff @(posedge clk) begin
        if (load_pc) begin
            pc <= next_pc;
        end
        if (load_addr) begin
            data_addr <= c_value[addr_width-1:0]; // Word address from ALU result
        end
    end

    // PC for fetch, data address for LDR and STR
    assign mem_addr = addr_sel ? pc : data_addr;

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import cpu_pkg::*; (
    input wire logic clk,
    input wire logic [word_width-1:0] read_data,
    input wire logic [word_width-1:0] sximm5,
    input wire logic [word_width-1:0] sximm8,
    input wire logic [reg_num_width-1:0] readnum,
    input wire logic [reg_num_width-1:0] writenum,
    input wire logic write,
    input wire logic loada,
    input wire logic loadb,
    input wire logic loadc,
    input wire logic loads,
    input wire logic asel,
    input wire logic bsel,
    input wire logic [1:0] vsel,
    input wire logic [1:0] shift,
    input wire logic [1:0] alu_op,
    output logic [word_width-1:0] write_data,
    output logic n,
    output logic v,
    output logic z
);

    logic [word_width-1:0] data_in;
    logic [word_width-1:0] reg_out;
    logic [word_width-1:0] a_reg, b_reg, c_reg;
    logic [word_width-1:0] a_in;
    logic [word_width-1:0] alu_result;
    logic alu_z, alu_n, alu_v;

    always_comb begin
        case (vsel)
            vsel_mdata: data_in = read_data;
            vsel_imm8: data_in = sximm8;
            default: data_in = c_reg;
        endcase
    end

    regfile u_regfile (
        .clk(clk),
        .write(write),
        .writenum(writenum),
        .readnum(readnum),
        .data_in(data_in),
        .data_out(reg_out)
    );

    always_ff @(posedge clk) begin
        if (loada) a_reg <= reg_out;
        if (loadb) b_reg <= reg_out;
        if (loadc) c_reg <= alu_result;
        if (loads) begin
            z <= alu_z;
            n <= alu_n;
            v <= alu_v;
        end
    end

    assign a_in = asel ? '0 : a_reg;

    alu u_alu (
        .a(a_in),
        .b_raw(b_reg),
        .sximm5(sximm5),
        .bsel(bsel),
        .shift(shift),
        .alu_op(alu_op),
        .result(alu_result),
        .z(alu_z),
        .n(alu_n),
        .v(alu_v)
    );

    assign write_data = c_reg;

endmodule

`default_nettype wire

//--- verilog/controller.sv
`timescale 1ns/1ps
`default_nettype none

module controller import cpu_pkg::*; (
    input wire logic clk,
    input wire logic reset,
    input wire logic [2:0] opcode,
    input wire logic [1:0] op,
    output logic [2:0] nsel,
    output logic write,
    output logic loada,
    output logic loadb,
    output logic loadc,
    output logic loads,
    output logic asel,
    output logic bsel,
    output logic [1:0] vsel,
    output logic [1:0] alu_op,
    output logic load_ir,
    output logic load_pc,
    output logic reset_pc,
    output logic load_addr,
    output logic addr_sel,
    output logic [1:0] mem_cmd,
    output logic halted
);

    logic [4:0] state;
    logic [4:0] next_state;
    logic is_mem_op;
    logic zero_a; // MOV reg and MVN run without Rn

    assign is_mem_op = (opcode == op_ldr) || (opcode == op_str);
    assign zero_a = (opcode == op_move) || (opcode == op_alu && op == alu_mvn);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_reset: next_state = st_if1;
            st_if1: next_state = st_if2;
            st_if2: next_state = st_update_pc;
            st_update_pc: next_state = st_decode;
            st_decode: begin
                case (opcode)
                    op_alu: next_state = (op == alu_mvn) ? st_get_b : st_get_a;
                    op_move: begin
                        if (op == mov_imm) begin
                            next_state = st_write_reg;
                        end else if (op == mov_reg) begin
                            next_state = st_get_b;
                        end else begin
                            next_state = st_if1;
                        end
                    end
                    op_ldr, op_str: next_state = st_get_a;
                    op_halt: next_state = st_halt;
                    default: next_state = st_if1; // Unknown opcode does nothing
                endcase
            end
            st_get_a: next_state = is_mem_op ? st_execute : st_get_b;
            st_get_b: begin
                if (opcode == op_alu && op == alu_cmp) begin
                    next_state = st_compare;
                end else begin
                    next_state = st_execute;
                end
            end
            st_execute: next_state = is_mem_op ? st_load_addr : st_write_reg;
            st_compare: next_state = st_if1;
            st_load_addr: next_state = (opcode == op_ldr) ? st_mem_read : st_get_d;
            st_mem_read: next_state = st_write_reg;
            st_get_d: next_state = st_pass_d;
            st_pass_d: next_state = st_mem_write;
            st_mem_write: next_state = st_write_reg;
            st_write_reg: next_state = st_if1;
            st_halt: next_state = st_halt; // Left only by reset
            default: next_state = st_reset;
        endcase
    end

    always_comb begin
        nsel = sel_rn;
        write = 1'b0;
        loada = 1'b0;
        loadb = 1'b0;
        loadc = 1'b0;
        loads = 1'b0;
        asel = 1'b0;
        bsel = 1'b0;
        vsel = vsel_c;
        alu_op = alu_add;
        load_ir = 1'b0;
        load_pc = 1'b0;
        reset_pc = 1'b0;
        load_addr = 1'b0;
        addr_sel = 1'b0;
        mem_cmd = mem_none;
        case (state)
            st_reset: begin
                load_pc = 1'b1;
                reset_pc = 1'b1;
            end
            st_if1: begin
                addr_sel = 1'b1;
                mem_cmd = mem_read;
            end
            st_if2: begin
                addr_sel = 1'b1;
                mem_cmd = mem_read;
                load_ir = 1'b1;
            end
            st_update_pc: load_pc = 1'b1;
            st_get_a: begin
                nsel = sel_rn;
                loada = 1'b1;
            end
            st_get_b: begin
                nsel = sel_rm;
                loadb = 1'b1;
            end
            st_execute: begin
                loadc = 1'b1;
                asel = zero_a;
                bsel = is_mem_op; // Base plus offset
                alu_op = (opcode == op_alu) ? op : alu_add;
            end
            st_compare: begin
                loads = 1'b1;
                alu_op = alu_cmp;
            end
            st_load_addr: load_addr = 1'b1;
            st_mem_read: mem_cmd = mem_read;
            st_get_d: begin
                nsel = sel_rd;
                loadb = 1'b1;
            end
            st_pass_d: begin
                loadc = 1'b1;
                asel = 1'b1;
            end
            st_mem_write: mem_cmd = mem_write;
            st_write_reg: begin
                if (opcode == op_move && op == mov_imm) begin
                    nsel = sel_rn;
                    vsel = vsel_imm8;
                    write = 1'b1;
                end else if (opcode == op_ldr) begin
                    nsel = sel_rd;
                    vsel = vsel_mdata;
                    mem_cmd = mem_read; // Hold read data for the write
                    write = 1'b1;
                end else if (opcode != op_str) begin
                    nsel = sel_rd;
                    write = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign halted = (state == st_halt);

endmodule

`default_nettype wire

//--- verilog/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder import cpu_pkg::*; (
    input wire logic clk,
    input wire logic load_ir,
    input wire logic [word_width-1:0] read_data,
    input wire logic [2:0] nsel,
    output logic [2:0] opcode,
    output logic [1:0] op,
    output logic [1:0] shift,
    output logic [reg_num_width-1:0] readnum,
    output logic [reg_num_width-1:0] writenum,
    output logic [word_width-1:0] sximm5,
    output logic [word_width-1:0] sximm8
);

    instr_t ir;

    always_ff @(posedge clk) begin
        if (load_ir) begin
            ir <= read_data;
        end
    end

    assign opcode = ir.reg_view.opcode;
    assign op = ir.reg_view.op;

    // STR passes Rd through B unshifted
    assign shift = (opcode == op_str) ? sh_none : ir.reg_view.shift;

    assign sximm8 = {{(word_width - 8){ir.imm8_view.imm8[7]}}, ir.imm8_view.imm8};
    assign sximm5 = {{(word_width - 5){ir.imm5_view.imm5[4]}}, ir.imm5_view.imm5};

    always_comb begin
        case (nsel)
            sel_rm: readnum = ir.reg_view.rm;
            sel_rd: readnum = ir.reg_view.rd;
            default: readnum = ir.reg_view.rn;
        endcase
    end

    assign writenum = readnum; // One register select for both ports

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
    input wire logic [word_width-1:0] a,
    input wire logic [word_width-1:0] b_raw,
    input wire logic [word_width-1:0] sximm5,
    input wire logic bsel,
    input wire logic [1:0] shift,
    input wire logic [1:0] alu_op,
    output logic [word_width-1:0] result,
    output logic z,
    output logic n,
    output logic v
);

    logic [word_width-1:0] b_shifted;
    logic [word_width-1:0] b;
    logic [word_width-1:0] diff;

    always_comb begin
        case (shift)
            sh_lsl: b_shifted = {b_raw[word_width-2:0], 1'b0};
            sh_lsr: b_shifted = {1'b0, b_raw[word_width-1:1]};
            sh_asr: b_shifted = {b_raw[word_width-1], b_raw[word_width-1:1]};
            default: b_shifted = b_raw;
        endcase
    end

    assign b = bsel ? sximm5 : b_shifted;
    assign diff = a - b;

    always_comb begin
        case (alu_op)
            alu_add: result = a + b;
            alu_cmp: result = diff;
            alu_and: result = a & b;
            default: result = ~b; // MVN
        endcase
    end

    assign z = (result == '0);
    assign n = result[word_width-1];
    // Signed overflow of a - b
    assign v = (a[word_width-1] != b[word_width-1]) && (diff[word_width-1] != a[word_width-1]);

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import cpu_pkg::*; (
    input wire logic clk,
    input wire logic write,
    input wire logic [reg_num_width-1:0] writenum,
    input wire logic [reg_num_width-1:0] readnum,
    input wire logic [word_width-1:0] data_in,
    output logic [word_width-1:0] data_out
);

    localparam int num_regs = 1 << reg_num_width;

    logic [word_width-1:0] regs [num_regs];
    logic [num_regs-1:0] write_en;

    // One-hot write decode
    assign write_en = write ? (num_regs'(1) << writenum) : '0;

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_regs; i++) begin
            if (write_en[i]) begin
                regs[i] <= data_in;
            end
        end
    end

    assign data_out = regs[readnum];

endmodule

`default_nettype wire

//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_width = 16;
    localparam int reg_num_width = 3;

    // Opcodes
    localparam logic [2:0] op_alu = 3'b101;
    localparam logic [2:0] op_move = 3'b110;
    localparam logic [2:0] op_ldr = 3'b011;
    localparam logic [2:0] op_str = 3'b100;
    localparam logic [2:0] op_halt = 3'b111;

    localparam logic [1:0] alu_add = 2'b00;
    localparam logic [1:0] alu_cmp = 2'b01;
    localparam logic [1:0] alu_and = 2'b10;
    localparam logic [1:0] alu_mvn = 2'b11;
    localparam logic [1:0] mov_reg = 2'b00;
    localparam logic [1:0] mov_imm = 2'b10;

    // Shift by one place
    localparam logic [1:0] sh_none = 2'b00;
    localparam logic [1:0] sh_lsl = 2'b01;
    localparam logic [1:0] sh_lsr = 2'b10;
    localparam logic [1:0] sh_asr = 2'b11;

    localparam logic [1:0] mem_none = 2'b00;
    localparam logic [1:0] mem_write = 2'b01;
    localparam logic [1:0] mem_read = 2'b10;

    localparam logic [1:0] vsel_mdata = 2'b00; // Memory read data
    localparam logic [1:0] vsel_imm8 = 2'b01;
    localparam logic [1:0] vsel_c = 2'b11;

    localparam logic [2:0] sel_rm = 3'b001;
    localparam logic [2:0] sel_rd = 3'b010;
    localparam logic [2:0] sel_rn = 3'b100;

    localparam logic [4:0] st_reset = 5'b00000;
    localparam logic [4:0] st_if1 = 5'b10000;
    localparam logic [4:0] st_if2 = 5'b11000;
    localparam logic [4:0] st_update_pc = 5'b11111;
    localparam logic [4:0] st_decode = 5'b00001;
    localparam logic [4:0] st_get_a = 5'b00010;
    localparam logic [4:0] st_get_b = 5'b00011;
    localparam logic [4:0] st_execute = 5'b00100;
    localparam logic [4:0] st_compare = 5'b00110;
    localparam logic [4:0] st_load_addr = 5'b01001;
    localparam logic [4:0] st_mem_read = 5'b01010;
    localparam logic [4:0] st_get_d = 5'b01011;
    localparam logic [4:0] st_pass_d = 5'b01100;
    localparam logic [4:0] st_mem_write = 5'b01101;
    localparam logic [4:0] st_write_reg = 5'b00101;
    localparam logic [4:0] st_halt = 5'b11011;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        logic [2:0] rn;
        logic [2:0] rd;
        logic [1:0] shift;
        logic [2:0] rm;
    } reg_fields_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        logic [2:0] rn;
        logic [7:0] imm8;
    } imm8_fields_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] op;
        logic [2:0] rn;
        logic [2:0] rd;
        logic [4:0] imm5;
    } imm5_fields_t;

    // Three layouts of the same instruction word
    typedef union packed {
        reg_fields_t reg_view;
        imm8_fields_t imm8_view;
        imm5_fields_t imm5_view;
    } instr_t;

endpackage

`default_nettype wire
